// File: Makefile
# Verilator build and run for the RV32I decode and execute slice.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_rv_decode_execute
FILE_LIST ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Test passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: src.f
+incdir+src
src/rv_pkg.sv
src/reg_port_if.sv
src/instr_queue.sv
src/register_file.sv
src/decoder.sv
src/alu_execute.sv
src/rv_decode_execute.sv
testbench/tb_clock_gen.sv
testbench/tb_rv_decode_execute.sv

// File: src/alu_execute.sv
// Execute stage.
// ALU and branch compare, register write back, the result register
// and the result credit counter that drives advance for the whole slice.
`include "rv_core_macros.svh"

module alu_execute (
	input  logic              clk,
	input  logic              arst_n,
	input  rv_pkg::ex_state_t ex_state,
	reg_port_if.execute       regs,
	output logic              advance,
	input  logic              result_credit,
	output rv_pkg::result_t   result,
	output logic              result_valid
);

	localparam int CNT_W = $clog2(`RV_RESULT_CREDITS + 1);

	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [`RV_XLEN-1:0] alu_value;
	logic [`RV_XLEN-1:0] value;
	logic                taken;
	logic                emit;
	logic [CNT_W-1:0]    credits;

	assign op_a = ex_state.use_pc ? ex_state.pc : ex_state.rs1_data;
	assign op_b = ex_state.use_imm ? ex_state.imm : ex_state.rs2_data;

	always_comb
	begin
		alu_value = '0;
		taken = 1'b0;
		case (ex_state.alu_op)
			rv_pkg::ALU_ADD:      alu_value = op_a + op_b;
			rv_pkg::ALU_SUB:      alu_value = op_a - op_b;
			rv_pkg::ALU_SLL:      alu_value = op_a << op_b[4:0]; // only five shift bits count.
			rv_pkg::ALU_SLT:      alu_value = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			rv_pkg::ALU_SLTU:     alu_value = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
			rv_pkg::ALU_XOR:      alu_value = op_a ^ op_b;
			rv_pkg::ALU_SRL:      alu_value = op_a >> op_b[4:0];
			rv_pkg::ALU_SRA:      alu_value = $signed(op_a) >>> op_b[4:0];
			rv_pkg::ALU_OR:       alu_value = op_a | op_b;
			rv_pkg::ALU_AND:      alu_value = op_a & op_b;
			rv_pkg::ALU_PASS_IMM: alu_value = op_b;
			rv_pkg::ALU_BEQ:      taken = (op_a == op_b);
			rv_pkg::ALU_BNE:      taken = (op_a != op_b);
			rv_pkg::ALU_BLT:      taken = ($signed(op_a) < $signed(op_b));
			rv_pkg::ALU_BGE:      taken = ($signed(op_a) >= $signed(op_b));
			rv_pkg::ALU_BLTU:     taken = (op_a < op_b);
			rv_pkg::ALU_BGEU:     taken = (op_a >= op_b);
			default:              alu_value = '0;
		endcase
	end

	// a branch reports its target, whether it is taken or not.
	assign value = ex_state.branch ? ex_state.pc + ex_state.imm : alu_value;

	// the pipeline moves only while a result credit is in hand.
	assign advance = (credits != '0);
	assign emit = advance && ex_state.valid; // bubbles spend nothing.

	assign regs.wr_en = emit && ex_state.reg_write && ex_state.rd != 5'd0;
	assign regs.wr_addr = ex_state.rd;
	assign regs.wr_data = value;

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			result.pc <= ex_state.pc;
			result.rd <= ex_state.rd;
			result.value <= value;
			result.write <= ex_state.reg_write;
			result.branch_taken <= ex_state.branch && taken;
			result.illegal <= ex_state.illegal;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			result_valid <= 1'b0;
			credits <= CNT_W'(`RV_RESULT_CREDITS);
		end
		else
		begin
			result_valid <= emit; // high for one cycle per result.
			// the credit is spent on the edge that loads the result.
			if (result_credit && !emit)
				credits <= credits + 1'b1;
			else if (emit && !result_credit)
				credits <= credits - 1'b1;
		end
	end

endmodule

// File: src/decoder.sv
// RV32I decoder.
// decodes the queue head, reads both sources with bypass from the write port
// and registers one execute record per instruction.
`include "rv_core_macros.svh"

module decoder (
	input  logic              clk,
	input  logic              arst_n,
	input  rv_pkg::id_state_t id_state,
	input  logic              id_valid,
	input  logic              advance,
	reg_port_if.decode        regs,
	output rv_pkg::ex_state_t ex_state
);

	rv_pkg::instr_word_t instr;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_u;
	rv_pkg::ex_state_t   ex_next;

	// funct3 picks the operation, alt selects sub or the arithmetic shift.
	function automatic rv_pkg::alu_op_t arith_op(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001:  return rv_pkg::ALU_SLL;
			3'b010:  return rv_pkg::ALU_SLT;
			3'b011:  return rv_pkg::ALU_SLTU;
			3'b100:  return rv_pkg::ALU_XOR;
			3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110:  return rv_pkg::ALU_OR;
			default: return rv_pkg::ALU_AND;
		endcase
	endfunction

	assign instr = id_state.instr;
	assign regs.rs1_addr = instr.r.rs1;
	assign regs.rs2_addr = instr.r.rs2;

	assign imm_i = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
	assign imm_b = {{(`RV_XLEN-12){instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
		instr.b.imm_4_1, 1'b0}; // branch offsets are always even.
	assign imm_u = {instr.u.imm_31_12, 12'b0};

	always_comb
	begin
		ex_next = '0;
		ex_next.valid = id_valid;
		ex_next.pc = id_state.pc;
		ex_next.rd = instr.r.rd;
		// the record ahead writes on the same edge this one loads, so forward it.
		ex_next.rs1_data = (regs.wr_en && regs.wr_addr == instr.r.rs1 && instr.r.rs1 != 5'd0)
			? regs.wr_data : regs.rs1_data;
		ex_next.rs2_data = (regs.wr_en && regs.wr_addr == instr.r.rs2 && instr.r.rs2 != 5'd0)
			? regs.wr_data : regs.rs2_data;
		ex_next.imm = imm_i;
		ex_next.alu_op = rv_pkg::ALU_ADD;
		case (instr.r.opcode)
			rv_pkg::OPC_OP:
			begin
				ex_next.alu_op = arith_op(instr.r.funct3, instr.r.funct7[5]);
				ex_next.reg_write = 1'b1;
			end
			rv_pkg::OPC_OP_IMM:
			begin
				// there is no subi, so bit 30 matters only for the right shifts.
				ex_next.alu_op = arith_op(instr.i.funct3,
					instr.i.funct3 == 3'b101 && instr.r.funct7[5]);
				ex_next.use_imm = 1'b1;
				ex_next.reg_write = 1'b1;
			end
			rv_pkg::OPC_LUI:
			begin
				ex_next.imm = imm_u;
				ex_next.alu_op = rv_pkg::ALU_PASS_IMM;
				ex_next.use_imm = 1'b1;
				ex_next.reg_write = 1'b1;
			end
			rv_pkg::OPC_AUIPC:
			begin
				ex_next.imm = imm_u; // added to the pc in execute.
				ex_next.use_imm = 1'b1;
				ex_next.use_pc = 1'b1;
				ex_next.reg_write = 1'b1;
			end
			rv_pkg::OPC_BRANCH:
			begin
				ex_next.imm = imm_b;
				ex_next.branch = 1'b1;
				case (instr.b.funct3)
					3'b000:  ex_next.alu_op = rv_pkg::ALU_BEQ;
					3'b001:  ex_next.alu_op = rv_pkg::ALU_BNE;
					3'b100:  ex_next.alu_op = rv_pkg::ALU_BLT;
					3'b101:  ex_next.alu_op = rv_pkg::ALU_BGE;
					3'b110:  ex_next.alu_op = rv_pkg::ALU_BLTU;
					3'b111:  ex_next.alu_op = rv_pkg::ALU_BGEU;
					default: ex_next.illegal = 1'b1; // funct3 010 and 011 are reserved.
				endcase
			end
			default: ex_next.illegal = 1'b1; // loads, stores and anything unknown.
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			ex_state <= '0;
		else if (advance)
			ex_state <= ex_next; // an empty queue loads a bubble.
	end

endmodule

// File: src/instr_queue.sv
// Instruction queue.
// circular FIFO of pc and instruction pairs, one upstream credit per pop.
`include "rv_core_macros.svh"

module instr_queue (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              push,
	input  rv_pkg::id_state_t push_data,
	input  logic              advance,
	output rv_pkg::id_state_t head,
	output logic              head_valid,
	output logic              credit
);

	localparam int DEPTH = `RV_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	rv_pkg::id_state_t mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              pop;

	assign head_valid = (count != '0);
	assign head = mem[rd_ptr]; // the decoder sees the head as soon as it lands.
	assign pop = advance && head_valid;

	// the fetch source never pushes without a credit, so no full check here.
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap at depth.
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			credit <= pop; // one cycle pulse per freed entry.
		end
	end

endmodule

// File: src/reg_port_if.sv
// Register file port bundle.
// two read ports for decode and the single write port driven by execute.
`include "rv_core_macros.svh"

interface reg_port_if;

	logic [4:0]          rs1_addr;
	logic [4:0]          rs2_addr;
	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic                wr_en;
	logic [4:0]          wr_addr;
	logic [`RV_XLEN-1:0] wr_data;

	// decode also watches the write port, which is its bypass source.
	modport decode (output rs1_addr, rs2_addr, input rs1_data, rs2_data, wr_en, wr_addr, wr_data);
	modport execute (output wr_en, wr_addr, wr_data);
	modport regfile (input rs1_addr, rs2_addr, wr_en, wr_addr, wr_data, output rs1_data, rs2_data);

endinterface

// File: src/register_file.sv
// Integer register file.
// x1 to x31 with two combinational reads and one write, x0 always reads zero.
`include "rv_core_macros.svh"

module register_file (
	input  logic       clk,
	input  logic       arst_n,
	reg_port_if.regfile regs
);

	logic [`RV_XLEN-1:0] gpr [1:31]; // x0 has no storage.

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 1; i < 32; i++)
				gpr[i] <= '0;
		end
		else if (regs.wr_en && regs.wr_addr != 5'd0)
		begin
			gpr[regs.wr_addr] <= regs.wr_data; // writes to x0 fall away.
		end
	end

	// reads are combinational, the decoder samples them in the same cycle.
	always_comb
	begin
		if (regs.rs1_addr == 5'd0)
			regs.rs1_data = '0;
		else
			regs.rs1_data = gpr[regs.rs1_addr];
	end

	always_comb
	begin
		if (regs.rs2_addr == 5'd0)
			regs.rs2_data = '0;
		else
			regs.rs2_data = gpr[regs.rs2_addr];
	end

endmodule

// File: src/rv_core_macros.svh
// RV32I decode and execute slice parameters.
// widths and depths shared by the package, the interface and the RTL.

`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data and program counter width in bits.
`define RV_XLEN 32

// instruction queue entries, also the fetch credits held after reset.
`define RV_QUEUE_DEPTH 4

// result credits the execute stage holds after reset.
`define RV_RESULT_CREDITS 2

`endif

// File: src/rv_decode_execute.sv
// RV32I decode and execute slice, top level.
// credit based instruction input, queue, decoder, register file and execute
// stage, with the result record spread onto plain output ports.
`include "rv_core_macros.svh"

module rv_decode_execute (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                instr_valid,
	input  logic [`RV_XLEN-1:0] instr_pc,
	input  logic [31:0]         instr_data,
	output logic                instr_credit,
	output logic                result_valid,
	output logic [`RV_XLEN-1:0] result_pc,
	output logic [4:0]          result_rd,
	output logic [`RV_XLEN-1:0] result_value,
	output logic                result_write,
	output logic                result_branch_taken,
	output logic                result_illegal,
	input  logic                result_credit
);

	rv_pkg::id_state_t push_data;
	rv_pkg::id_state_t head;
	logic              head_valid;
	logic              advance;
	rv_pkg::ex_state_t ex_state;
	rv_pkg::result_t   result;

	reg_port_if regs ();

	assign push_data = {instr_pc, instr_data}; // pc sits above the instruction word.

	instr_queue instr_queue_i (.clk(clk), .arst_n(arst_n), .push(instr_valid),
		.push_data(push_data), .advance(advance), .head(head), .head_valid(head_valid),
		.credit(instr_credit));

	register_file register_file_i (.clk(clk), .arst_n(arst_n), .regs(regs.regfile));

	decoder decoder_i (.clk(clk), .arst_n(arst_n), .id_state(head), .id_valid(head_valid),
		.advance(advance), .regs(regs.decode), .ex_state(ex_state));

	alu_execute alu_execute_i (.clk(clk), .arst_n(arst_n), .ex_state(ex_state),
		.regs(regs.execute), .advance(advance), .result_credit(result_credit),
		.result(result), .result_valid(result_valid));

	assign result_pc = result.pc;
	assign result_rd = result.rd;
	assign result_value = result.value;
	assign result_write = result.write;
	assign result_branch_taken = result.branch_taken;
	assign result_illegal = result.illegal;

endmodule

// File: src/rv_pkg.sv
// RV32I slice package.
// opcodes, the instruction word views, the ALU operations and the stage records.
`include "rv_core_macros.svh"

package rv_pkg;

	localparam logic [6:0] OPC_OP     = 7'b0110011; // register to register ALU.
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register and immediate ALU.
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011; // the six conditional branches.

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// the branch offset is scattered over the word, bit 0 is implied zero.
	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// one instruction word, read through whichever format the opcode calls for.
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		b_fmt_t b;
		u_fmt_t u;
	} instr_word_t;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_PASS_IMM, // lui passes the upper immediate straight through.
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} alu_op_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0] pc;
		instr_word_t         instr;
	} id_state_t;

	typedef struct packed {
		logic                valid;
		logic [`RV_XLEN-1:0] pc;
		logic [4:0]          rd;
		logic [`RV_XLEN-1:0] rs1_data; // already bypassed in decode.
		logic [`RV_XLEN-1:0] rs2_data;
		logic [`RV_XLEN-1:0] imm;
		alu_op_t             alu_op;
		logic                use_imm;  // second operand is the immediate.
		logic                use_pc;   // first operand is the pc.
		logic                branch;
		logic                reg_write;
		logic                illegal;
	} ex_state_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0] pc;
		logic [4:0]          rd;
		logic [`RV_XLEN-1:0] value; // the branch target for branches.
		logic                write;
		logic                branch_taken;
		logic                illegal;
	} result_t;

endpackage

// File: testbench/tb_clock_gen.sv
// Testbench clock and reset source.
// free running clock and an active low reset held for the first cycles.

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 10, // a full period of 20 time units.
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic arst_n
);

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// reset drops on a falling edge, away from the edge the DUT samples on.
	initial
	begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

// File: testbench/tb_rv_decode_execute.sv
// Testbench for the RV32I decode and execute slice.
// feeds a table of instructions under fetch credits, returns result credits
// after random delays and checks every result against the table in order.
`include "rv_core_macros.svh"

module tb_rv_decode_execute;

	typedef struct {
		logic [`RV_XLEN-1:0] pc;
		logic [31:0]         instr;
		logic [4:0]          rd;
		logic [`RV_XLEN-1:0] value;
		logic                write;
		logic                taken;
		logic                illegal;
	} step_t;

	logic                clk;
	logic                arst_n;
	logic                instr_valid;
	logic [`RV_XLEN-1:0] instr_pc;
	logic [31:0]         instr_data;
	logic                instr_credit;
	logic                result_valid;
	logic [`RV_XLEN-1:0] result_pc;
	logic [4:0]          result_rd;
	logic [`RV_XLEN-1:0] result_value;
	logic                result_write;
	logic                result_branch_taken;
	logic                result_illegal;
	logic                result_credit;

	step_t steps[$];
	bit    table_ready;
	int    results_seen;

	tb_clock_gen clock_gen_i (.clk(clk), .arst_n(arst_n));

	rv_decode_execute rv_decode_execute_i (.clk(clk), .arst_n(arst_n),
		.instr_valid(instr_valid), .instr_pc(instr_pc), .instr_data(instr_data),
		.instr_credit(instr_credit), .result_valid(result_valid), .result_pc(result_pc),
		.result_rd(result_rd), .result_value(result_value), .result_write(result_write),
		.result_branch_taken(result_branch_taken), .result_illegal(result_illegal),
		.result_credit(result_credit));

	// each entry sits one word after the previous one, starting at 0x100.
	function automatic void add_step(input logic [31:0] instr, input logic [4:0] rd,
		input logic [`RV_XLEN-1:0] value, input logic write, input logic taken,
		input logic illegal);
		step_t s;
		s.pc = `RV_XLEN'(32'h100 + 4 * steps.size());
		s.instr = instr;
		s.rd = rd;
		s.value = value;
		s.write = write;
		s.taken = taken;
		s.illegal = illegal;
		steps.push_back(s);
	endfunction

	task automatic check_word(input string name, input logic [`RV_XLEN-1:0] got,
		input logic [`RV_XLEN-1:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Test failed");
			$fatal(1, "result word compare stopped the run");
		end
	endtask

	task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Test failed");
			$fatal(1, "register index compare stopped the run");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Test failed");
			$fatal(1, "result flag compare stopped the run");
		end
	endtask

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "protocol check stopped the run");
	endtask

	// instructions, destination and expected result, all worked out by hand.
	task automatic build_table();
		add_step(32'hFFB00093, 5'd1, 32'hFFFFFFFB, 1, 0, 0);  // addi x1, x0, -5.
		add_step(32'h00700113, 5'd2, 32'h00000007, 1, 0, 0);  // addi x2, x0, 7.
		add_step(32'h002081B3, 5'd3, 32'h00000002, 1, 0, 0);  // add x3, x1, x2 via bypass.
		add_step(32'h40208233, 5'd4, 32'hFFFFFFF4, 1, 0, 0);  // sub x4, x1, x2.
		add_step(32'h0020A2B3, 5'd5, 32'h00000001, 1, 0, 0);  // slt, -5 is below 7.
		add_step(32'h0020B333, 5'd6, 32'h00000000, 1, 0, 0);  // sltu, 0xfffffffb is not.
		add_step(32'h4010D393, 5'd7, 32'hFFFFFFFD, 1, 0, 0);  // srai x7, x1, 1.
		add_step(32'h0040D413, 5'd8, 32'h0FFFFFFF, 1, 0, 0);  // srli x8, x1, 4.
		add_step(32'h0F014493, 5'd9, 32'h000000F7, 1, 0, 0);  // xori x9, x2, 0xf0.
		add_step(32'h80001537, 5'd10, 32'h80001000, 1, 0, 0); // lui x10, 0x80001.
		add_step(32'h00002597, 5'd11, 32'h00002128, 1, 0, 0); // auipc at 0x128.
		add_step(32'h00510013, 5'd0, 32'h0000000C, 1, 0, 0);  // addi x0, x2, 5.
		add_step(32'h00200633, 5'd12, 32'h00000007, 1, 0, 0); // add x12, x0, x2, x0 stays zero.
		add_step(32'h009566B3, 5'd13, 32'h800010F7, 1, 0, 0); // or x13, x10, x9.
		add_step(32'h0016F733, 5'd14, 32'h800010F3, 1, 0, 0); // and x14, x13, x1.
		add_step(32'h002117B3, 5'd15, 32'h00000380, 1, 0, 0); // sll x15, x2, x2.
		add_step(32'h00108863, 5'd16, 32'h00000150, 0, 1, 0); // beq x1, x1, +16.
		add_step(32'hFE109CE3, 5'd25, 32'h0000013C, 0, 0, 0); // bne x1, x1, -8.
		add_step(32'h0020C863, 5'd16, 32'h00000158, 0, 1, 0); // blt x1, x2, +16.
		add_step(32'hFE20DCE3, 5'd25, 32'h00000144, 0, 0, 0); // bge x1, x2, -8.
		add_step(32'h0020E863, 5'd16, 32'h00000160, 0, 0, 0); // bltu x1, x2, +16.
		add_step(32'hFE20FCE3, 5'd25, 32'h0000014C, 0, 1, 0); // bgeu x1, x2, -8.
		add_step(32'h00012283, 5'd5, 32'h00000000, 0, 0, 1);  // lw x5, 0(x2).
		add_step(32'h00112423, 5'd8, 32'h00000000, 0, 0, 1);  // sw x1, 8(x2).
		add_step(32'h000003FF, 5'd7, 32'h00000000, 0, 0, 1);  // opcode 0x7f is unknown.
		add_step(32'h00028813, 5'd16, 32'h00000001, 1, 0, 0); // x5 kept its slt value.
		add_step(32'h00040893, 5'd17, 32'h0FFFFFFF, 1, 0, 0); // x8 kept its srli value.
		add_step(32'h00038913, 5'd18, 32'hFFFFFFFD, 1, 0, 0); // x7 kept its srai value.
	endtask

	// fetch source, which pushes only while it holds a queue credit.
	initial
	begin
		int fetch_credits;
		int issue_idx;
		instr_valid = 1'b0;
		instr_pc = '0;
		instr_data = '0;
		fetch_credits = `RV_QUEUE_DEPTH;
		issue_idx = 0;
		build_table();
		table_ready = 1'b1;
		wait (arst_n === 1'b1);
		while (results_seen < steps.size())
		begin
			@(negedge clk);
			if (instr_credit)
				fetch_credits++; // one entry left the queue.
			if (fetch_credits > `RV_QUEUE_DEPTH)
				stop_run("the queue returned more credits than it has entries");
			if (issue_idx < steps.size() && fetch_credits > 0)
			begin
				instr_valid = 1'b1;
				instr_pc = steps[issue_idx].pc;
				instr_data = steps[issue_idx].instr;
				fetch_credits--;
				issue_idx++;
			end
			else
			begin
				instr_valid = 1'b0;
			end
		end
		instr_valid = 1'b0;
		repeat (8) @(negedge clk); // any stray result shows up here.
		$display("Test passed");
		$finish;
	end

	// result consumer, which checks each result and hands its credit back later.
	initial
	begin
		int slice_credits;
		int pending_returns;
		int return_wait;
		step_t exp;
		void'($urandom(32'he1a1_083b));
		result_credit = 1'b0;
		slice_credits = `RV_RESULT_CREDITS;
		pending_returns = 0;
		return_wait = 0;
		forever
		begin
			@(negedge clk);
			result_credit = 1'b0;
			if (arst_n && result_valid)
			begin
				if (results_seen >= steps.size())
					stop_run("a result arrived after the last instruction of the table");
				if (slice_credits == 0)
					stop_run("result_valid fired while the slice held no result credit");
				slice_credits--;
				exp = steps[results_seen];
				check_word($sformatf("result_pc[%0d]", results_seen), result_pc, exp.pc);
				check_reg($sformatf("result_rd[%0d]", results_seen), result_rd, exp.rd);
				check_flag($sformatf("result_write[%0d]", results_seen), result_write, exp.write);
				check_flag($sformatf("result_branch_taken[%0d]", results_seen),
					result_branch_taken, exp.taken);
				check_flag($sformatf("result_illegal[%0d]", results_seen),
					result_illegal, exp.illegal);
				// the value of a load, store or unknown word carries no meaning.
				if (!exp.illegal)
				begin
					check_word($sformatf("result_value[%0d]", results_seen),
						result_value, exp.value);
				end
				if (pending_returns == 0)
					return_wait = $urandom % 7;
				pending_returns++;
				results_seen++;
			end
			if (pending_returns > 0)
			begin
				if (return_wait == 0)
				begin
					result_credit = 1'b1; // a one cycle pulse returns one credit.
					pending_returns--;
					slice_credits++;
					return_wait = $urandom % 7;
				end
				else
				begin
					return_wait--;
				end
			end
		end
	end

	// the run budget grows with the table.
	initial
	begin
		wait (table_ready);
		repeat (steps.size() * 40) @(posedge clk);
		$display("results stopped arriving, %0d of %0d seen before the timeout",
			results_seen, steps.size());
		$display("Test failed");
		$fatal(1, "watchdog timeout");
	end

endmodule
